// File: compile.f
lc3b_types.sv
regfile.sv
alu.sv
ir.sv
datapath.sv
control.sv
cpu.sv
tb_memory.sv
tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import lc3b_types::*; ();

    localparam lc3b_word reset_pc = 16'h0000;
    localparam int       n_prog   = 31;
    localparam int       n_store  = 9;

    // Each row is {byte address, word}
    localparam logic [31:0] prog_tbl [n_prog] = '{
        {16'h0000, 16'h6C1F},                      // LDR R6, R0, #31 reads 0x003E
        {16'h0002, 16'h7D80},                      // STR R6, R6, #0
        {16'h0004, 16'h6BBE},                      // LDR R5, R6, #-2 reads 0x00FC
        {16'h0006, 16'h7B81},                      // STR R5, R6, #1
        {16'h0008, 16'h1227},                      // ADD R1, R0, #7
        {16'h000A, 16'h147D},                      // ADD R2, R1, #-3
        {16'h000C, 16'h1642},                      // ADD R3, R1, R2
        {16'h000E, 16'h7782},                      // STR R3, R6, #2
        {16'h0010, 16'h58C5},                      // AND R4, R3, R5
        {16'h0012, 16'h7983},                      // STR R4, R6, #3
        {16'h0014, 16'h58FE},                      // AND R4, R3, #-2
        {16'h0016, 16'h7984},                      // STR R4, R6, #4
        {16'h0018, 16'h98FF},                      // NOT R4, R3 sets n
        {16'h001A, 16'h7985},                      // STR R4, R6, #5
        {16'h001C, 16'h0801},                      // BRn +1 is taken
        {16'h001E, 16'h719F},                      // STR R0, R6, #31 is skipped
        {16'h0020, 16'h0601},                      // BRzp +1 falls through
        {16'h0022, 16'h7386},                      // STR R1, R6, #6
        {16'h0024, 16'h5E20},                      // AND R7, R0, #0 sets z
        {16'h0026, 16'h0A01},                      // BRnp +1 falls through
        {16'h0028, 16'h0401},                      // BRz +1 is taken
        {16'h002A, 16'h719E},                      // STR R0, R6, #30 is skipped
        {16'h002C, 16'h7587},                      // STR R2, R6, #7
        {16'h002E, 16'h1FE5},                      // ADD R7, R7, #5 sets p
        {16'h0030, 16'h0201},                      // BRp +1 is taken
        {16'h0032, 16'h719D},                      // STR R0, R6, #29 is skipped
        {16'h0034, 16'h0C01},                      // BRnz +1 falls through
        {16'h0036, 16'h7F88},                      // STR R7, R6, #8
        {16'h0038, 16'h0FFF},                      // BRnzp to itself
        {16'h003E, 16'h0100},                      // Data, base pointer
        {16'h00FC, 16'h8001}                       // Data, negative word
    };

    // Each row is {store address, store data}
    localparam logic [31:0] store_tbl [n_store] = '{
        {16'h0100, 16'h0100},                      // R6 from 31*2 = 0x3E, stored at R6
        {16'h0102, 16'h8001},                      // R5 from 0x0100 - 2*2 = 0x00FC
        {16'h0104, 16'h000B},                      // R1 = 7, R2 = 7 - 3 = 4, R3 = 11
        {16'h0106, 16'h0001},                      // 0x000B & 0x8001
        {16'h0108, 16'h000A},                      // 0x000B & sext(-2) = 0xFFFE
        {16'h010A, 16'hFFF4},                      // ~0x000B
        {16'h010C, 16'h0007},                      // R1 after BRn skipped 0x013E
        {16'h010E, 16'h0004},                      // R2 after BRz skipped 0x013C
        {16'h0110, 16'h0005}                       // R7 = 0 + 5, BRp skipped 0x013A, BRnz not
    };

    logic     clk;
    logic     arst_n;
    lc3b_word mem_rdata;
    logic     mem_resp;
    logic     mem_read;
    logic     mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;

    cpu #(
        .reset_pc (reset_pc)
    ) uut (
        .clk,
        .arst_n,
        .mem_rdata,
        .mem_resp,
        .mem_read,
        .mem_write,
        .mem_address,
        .mem_wdata
    );

    tb_memory u_mem (
        .clk,
        .arst_n,
        .mem_read,
        .mem_write,
        .mem_address,
        .mem_wdata,
        .mem_rdata,
        .mem_resp
    );

    task automatic check(input string name, input lc3b_word expected, input lc3b_word actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR %s", what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Bus monitors
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (arst_n && mem_read && mem_write) begin
            stop_with_error("mem_read and mem_write are high together");
        end
    end

    initial begin
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check("strobes low around reset", 16'h0000, {14'b0, mem_read, mem_write});
        end
    end

    initial begin
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(arst_n && mem_read) && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_read) begin
            stop_with_error("the first instruction fetch never started");
        end
        check("first fetch address", reset_pc, mem_address);
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int waited;
        arst_n = 1'b0;
        #1;
        for (int i = 0; i < n_prog; i++) begin
            u_mem.mem[prog_tbl[i][31:17]] = prog_tbl[i][15:0];
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int k = 0; k < n_store; k++) begin
            waited = 0;
            while (u_mem.log_count <= k && waited < 2000) begin
                @(negedge clk);
                waited++;
            end
            if (u_mem.log_count <= k) begin
                stop_with_error($sformatf("store %0d to address %h never came",
                                          k, store_tbl[k][31:16]));
            end
            check($sformatf("store %0d address", k), store_tbl[k][31:16], u_mem.log_addr[k]);
            check($sformatf("store %0d data", k), store_tbl[k][15:0], u_mem.log_data[k]);
        end

        waited = 0;
        while (u_mem.log_count == n_store && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (u_mem.log_count != n_store) begin
            stop_with_error($sformatf("an extra store to address %h appeared",
                                      u_mem.log_addr[n_store]));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: tb_memory.sv
`timescale 1ns/1ps

module tb_memory import lc3b_types::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     mem_read,
    input  logic     mem_write,
    input  lc3b_word mem_address,
    input  lc3b_word mem_wdata,
    output lc3b_word mem_rdata,
    output logic     mem_resp
);

    lc3b_word mem [32768];                         // Indexed by address bits 15 to 1
    lc3b_word log_addr [64];
    lc3b_word log_data [64];
    int       log_count;
    integer   seed;
    int       delay;

    initial begin
        seed      = 26775;
        log_count = 0;
        mem_rdata = '0;
        mem_resp  = 1'b0;
        for (int i = 0; i < 32768; i++) begin
            mem[i] = {i[14:0], 1'b0} ^ 16'hA5A5;   // Every word differs from its neighbours
        end
    end

    // ----------------------------------------------------------
    // Strobe service with 0 to 3 extra cycles of latency
    // ----------------------------------------------------------
    initial begin
        forever begin
            @(posedge clk);
            #2;
            mem_resp = 1'b0;
            if (arst_n && (mem_read || mem_write)) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                if (mem_write) begin
                    mem[mem_address[15:1]] = mem_wdata;
                    if (log_count < 64) begin
                        log_addr[log_count] = mem_address;
                        log_data[log_count] = mem_wdata;
                    end
                    log_count++;
                end else begin
                    mem_rdata = mem[mem_address[15:1]];
                end
                mem_resp = 1'b1;                   // Dropped again after one cycle
            end
        end
    end

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu import lc3b_types::*; #(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic     clk,
    input  logic     arst_n,
    input  lc3b_word mem_rdata,
    input  logic     mem_resp,
    output logic     mem_read,
    output logic     mem_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata
);

    lc3b_ctrl   ctrl;
    lc3b_status status;

    control u_control (
        .clk,
        .arst_n,
        .status,
        .mem_resp,
        .ctrl,
        .mem_read,
        .mem_write
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk,
        .arst_n,
        .ctrl,
        .mem_rdata,
        .mem_address,
        .mem_wdata,
        .status
    );

endmodule

// File: control.sv
`timescale 1ns/1ps

module control import lc3b_types::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  lc3b_status status,
    input  logic       mem_resp,
    output lc3b_ctrl   ctrl,
    output logic       mem_read,
    output logic       mem_write
);

    typedef enum logic [3:0] {
        fetch1,
        fetch2,
        fetch3,
        decode,
        s_add,
        s_and,
        s_not,
        s_br,
        calc_addr,
        ld1,
        ld2,
        st1,
        st2
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= fetch1;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------------------------
    // Control word per state
    // ----------------------------------------------------------
    always_comb begin
        ctrl      = '0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (state)
            fetch1: begin
                ctrl.marmux_sel = 1'b1;
                ctrl.load_mar   = 1'b1;
                ctrl.load_pc    = 1'b1;
            end
            fetch2, ld1: begin
                mem_read        = 1'b1;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = mem_resp;
            end
            fetch3: begin
                ctrl.load_ir = 1'b1;
            end
            s_add, s_and: begin
                ctrl.aluop        = (state == s_and) ? alu_and : alu_add;
                ctrl.alumux_sel   = {1'b0, status.inst5};
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            s_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            s_br: begin
                ctrl.pcmux_sel = 1'b1;
                ctrl.load_pc   = status.branch_enable;
            end
            calc_addr: begin
                ctrl.alumux_sel = 2'b10;
                ctrl.aluop      = alu_add;
                ctrl.load_mar   = 1'b1;
            end
            ld2: begin
                ctrl.regfilemux_sel = 2'b01;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end
            st1: begin
                ctrl.storemux_sel = 1'b1;
                ctrl.alumux_sel   = 2'b11;
                ctrl.aluop        = alu_pass;
                ctrl.load_mdr     = 1'b1;
            end
            st2: begin
                mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            fetch1:    next_state = fetch2;
            fetch2:    next_state = mem_resp ? fetch3 : fetch2;
            fetch3:    next_state = decode;
            decode: begin
                case (status.opcode)
                    op_add:  next_state = s_add;
                    op_and:  next_state = s_and;
                    op_not:  next_state = s_not;
                    op_br:   next_state = s_br;
                    op_ldr:  next_state = calc_addr;
                    op_str:  next_state = calc_addr;
                    default: next_state = fetch1;  // Skipped like a no-op
                endcase
            end
            calc_addr: next_state = (status.opcode == op_str) ? st1 : ld1;
            ld1:       next_state = mem_resp ? ld2 : ld1;
            st1:       next_state = st2;
            st2:       next_state = mem_resp ? fetch1 : st2;
            default:   next_state = fetch1;
        endcase
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write)
    );

    a_known_opcode: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == decode) |->
            (status.opcode inside {op_add, op_and, op_not, op_br, op_ldr, op_str})
    );

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath import lc3b_types::*; #(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic       clk,
    input  logic       arst_n,
    input  lc3b_ctrl   ctrl,
    input  lc3b_word   mem_rdata,
    output lc3b_word   mem_address,
    output lc3b_word   mem_wdata,
    output lc3b_status status
);

    lc3b_word    pc;
    lc3b_word    pc_plus2;
    lc3b_word    br_add;
    lc3b_word    pcmux_out;
    lc3b_word    mar;
    lc3b_word    marmux_out;
    lc3b_word    mdr;
    lc3b_word    mdrmux_out;
    lc3b_nzp     cc;
    lc3b_nzp     gencc;

    lc3b_opcode  opcode;
    logic        inst5;
    lc3b_reg     dest;
    lc3b_reg     src1;
    lc3b_reg     src2;
    lc3b_reg     storemux_out;
    lc3b_imm5    imm5;
    lc3b_offset6 offset6;
    lc3b_offset9 offset9;

    lc3b_word    sext5;
    lc3b_word    adj6;
    lc3b_word    adj9;
    lc3b_word    reg_a;
    lc3b_word    reg_b;
    lc3b_word    alumux_out;
    lc3b_word    alu_out;
    lc3b_word    regfilemux_out;

    // ----------------------------------------------------------
    // PC and memory registers
    // ----------------------------------------------------------
    assign pc_plus2  = pc + 16'd2;
    assign adj9      = {{6{offset9[8]}}, offset9, 1'b0};
    assign br_add    = pc + adj9;                  // PC already points past the BR
    assign pcmux_out = ctrl.pcmux_sel ? br_add : pc_plus2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
            cc <= '0;
        end else begin
            if (ctrl.load_pc) begin
                pc <= pcmux_out;
            end
            if (ctrl.load_cc) begin
                cc <= gencc;
            end
        end
    end

    assign marmux_out = ctrl.marmux_sel ? pc : alu_out;
    assign mdrmux_out = ctrl.mdrmux_sel ? mem_rdata : alu_out;

    always_ff @(posedge clk) begin
        if (ctrl.load_mar) begin
            mar <= marmux_out;
        end
        if (ctrl.load_mdr) begin
            mdr <= mdrmux_out;
        end
    end

    assign mem_address = mar;
    assign mem_wdata   = mdr;

    // ----------------------------------------------------------
    // Instruction register and register file
    // ----------------------------------------------------------
    ir u_ir (
        .clk,
        .arst_n,
        .load    (ctrl.load_ir),
        .in      (mdr),
        .opcode,
        .inst5,
        .dest,
        .src1,
        .src2,
        .imm5,
        .offset6,
        .offset9
    );

    assign storemux_out = ctrl.storemux_sel ? dest : src1;

    always_comb begin
        case (ctrl.regfilemux_sel)
            2'b01:   regfilemux_out = mdr;
            default: regfilemux_out = alu_out;
        endcase
    end

    regfile u_regfile (
        .clk,
        .arst_n,
        .load  (ctrl.load_regfile),
        .in    (regfilemux_out),
        .src_a (storemux_out),
        .src_b (src2),
        .dest,
        .reg_a,
        .reg_b
    );

    // ----------------------------------------------------------
    // ALU and operand select
    // ----------------------------------------------------------
    assign sext5 = {{11{imm5[4]}}, imm5};
    assign adj6  = {{9{offset6[5]}}, offset6, 1'b0};

    always_comb begin
        case (ctrl.alumux_sel)
            2'b00:   alumux_out = reg_b;
            2'b01:   alumux_out = sext5;
            2'b10:   alumux_out = adj6;
            default: alumux_out = reg_a;           // Store source for pass-through
        endcase
    end

    alu u_alu (
        .aluop (ctrl.aluop),
        .a     (reg_a),
        .b     (alumux_out),
        .f     (alu_out)
    );

    // ----------------------------------------------------------
    // Condition codes
    // ----------------------------------------------------------
    assign gencc[2] = regfilemux_out[15];
    assign gencc[1] = (regfilemux_out == '0);
    assign gencc[0] = !regfilemux_out[15] && (regfilemux_out != '0);

    assign status = '{
        opcode:        opcode,
        inst5:         inst5,
        branch_enable: |(dest & cc)
    };

    a_pc_even: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[0] == 1'b0
    );

endmodule

// File: ir.sv
`timescale 1ns/1ps

module ir import lc3b_types::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load,
    input  lc3b_word    in,
    output lc3b_opcode  opcode,
    output logic        inst5,
    output lc3b_reg     dest,
    output lc3b_reg     src1,
    output lc3b_reg     src2,
    output lc3b_imm5    imm5,
    output lc3b_offset6 offset6,
    output lc3b_offset9 offset9
);

    lc3b_instr instr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr <= '0;
        end else if (load) begin
            instr <= in;
        end
    end

    // ----------------------------------------------------------
    // Register and immediate view
    // ----------------------------------------------------------
    assign opcode = instr.rr.opcode;
    assign dest   = instr.rr.dest;
    assign src1   = instr.rr.src1;
    assign inst5  = instr.rr.inst5;
    assign imm5   = instr.rr.imm5;
    assign src2   = instr.rr.imm5[2:0];            // Bits 4:3 are zero in register form

    // ----------------------------------------------------------
    // Offset view
    // ----------------------------------------------------------
    assign offset6 = instr.off.offset6;
    assign offset9 = {instr.off.base, instr.off.offset6};

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu import lc3b_types::*; (
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    always_comb begin
        unique case (aluop)
            alu_add: begin
                f = a + b;
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;
            end
            alu_pass: begin
                f = b;                             // Moves a value to MDR for stores
            end
            default: begin
                f = a + b;
            end
        endcase
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile import lc3b_types::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  lc3b_word in,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_reg  dest,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word data [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // Reads see the old value during a write cycle
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

    // A write of unknown data would corrupt the architectural state silently
    a_write_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        load |-> !$isunknown(in)
    );

endmodule

// File: lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;                  // n, z, p from msb down

    typedef logic signed [4:0] lc3b_imm5;
    typedef logic signed [5:0] lc3b_offset6;
    typedef logic signed [8:0] lc3b_offset9;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // Register and immediate forms; src2 is the low three bits of imm5
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic       inst5;
        lc3b_imm5   imm5;
    } lc3b_rr_fmt;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dest;                         // Doubles as the nzp mask of BR
        lc3b_reg     base;
        lc3b_offset6 offset6;
    } lc3b_off_fmt;

    typedef union packed {
        lc3b_rr_fmt  rr;
        lc3b_off_fmt off;
    } lc3b_instr;

    // ----------------------------------------------------------
    // Control word and status between control and datapath
    // ----------------------------------------------------------
    typedef struct packed {
        logic       load_pc;
        logic       load_ir;
        logic       load_regfile;
        logic       load_mar;
        logic       load_mdr;
        logic       load_cc;
        logic       pcmux_sel;                     // 0 is pc + 2, 1 is branch target
        logic       storemux_sel;                  // 1 reads dest on port A
        logic [1:0] alumux_sel;
        logic [1:0] regfilemux_sel;
        logic       marmux_sel;                    // 0 is ALU, 1 is PC
        logic       mdrmux_sel;                    // 0 is ALU, 1 is memory
        lc3b_aluop  aluop;
    } lc3b_ctrl;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       inst5;
        logic       branch_enable;
    } lc3b_status;

endpackage
